/* logic/cpu_params_pkg.sv */
`default_nettype none

package cpu_params_pkg;

  // datapath widths
  parameter int DATA_WIDTH     = 32;
  parameter int ADDR_WIDTH     = 16; // byte address
  parameter int REGISTER_WIDTH = 5;

  // unified memory
  parameter int MEM_SIZE       = 1024; // in words
  parameter int READ_LATENCY   = 3;    // cycles from accept to rdata_valid

  typedef logic [DATA_WIDTH-1:0]     word_t;
  typedef logic [ADDR_WIDTH-1:0]     addr_t;
  typedef logic [REGISTER_WIDTH-1:0] reg_idx_t;

endpackage : cpu_params_pkg

`default_nettype wire

/* logic/mem_bus_pkg.sv */
`default_nettype none

package mem_bus_pkg;

  parameter int NUM_REQUESTERS = 2;

  // which client owns the shared memory
  typedef enum logic {
    REQ_FETCH = 1'b0,
    REQ_DATA  = 1'b1
  } requester_e;

endpackage : mem_bus_pkg

`default_nettype wire

/* logic/mem_port_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface mem_port_if #(
  parameter int DATA_WIDTH = 32,
  parameter int ADDR_WIDTH = 16
);

  logic                  rd_req;
  logic                  wr_req;
  logic [ADDR_WIDTH-1:0] addr;
  logic [DATA_WIDTH-1:0] wdata;
  logic [DATA_WIDTH-1:0] rdata;
  logic                  rdata_valid; // one-cycle read completion
  logic                  wr_done;     // one-cycle write completion

  modport requester (
    output rd_req, wr_req, addr, wdata,
    input  rdata, rdata_valid, wr_done
  );

  modport server (
    input  rd_req, wr_req, addr, wdata,
    output rdata, rdata_valid, wr_done
  );

endinterface : mem_port_if

`default_nettype wire

/* logic/fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
  parameter int DATA_WIDTH = cpu_params_pkg::DATA_WIDTH,
  parameter int ADDR_WIDTH = cpu_params_pkg::ADDR_WIDTH
)(
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  fetch_en_i,
  input  logic                  redirect_i,
  input  cpu_params_pkg::addr_t redirect_pc_i,
  output logic                  instr_valid_o,
  output cpu_params_pkg::word_t instr_o,
  output cpu_params_pkg::addr_t instr_pc_o,
  mem_port_if.requester         mem
);

  logic                  req_q;    // read outstanding
  logic                  stale_q;  // outstanding read belongs to an old pc
  logic [ADDR_WIDTH-1:0] pc_q;     // next pc to fetch
  logic [ADDR_WIDTH-1:0] req_pc_q; // pc of the outstanding read
  logic                  keep_word;

  assign mem.rd_req = req_q;
  assign mem.wr_req = 1'b0;
  assign mem.addr   = req_pc_q;
  assign mem.wdata  = {DATA_WIDTH{1'b0}};

  assign keep_word = req_q && mem.rdata_valid && !stale_q && !redirect_i;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      req_q         <= 1'b0;
      stale_q       <= 1'b0;
      pc_q          <= '0;
      instr_valid_o <= 1'b0;
    end else begin
      instr_valid_o <= keep_word;
      if (redirect_i) pc_q <= redirect_pc_i;
      if (req_q) begin
        if (redirect_i) stale_q <= 1'b1;
        if (mem.rdata_valid) begin
          req_q   <= 1'b0; // request drops after the pulse
          stale_q <= 1'b0;
          if (keep_word) pc_q <= req_pc_q + ADDR_WIDTH'(4);
        end
      end else if (fetch_en_i && !redirect_i) begin
        req_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!req_q) req_pc_q <= pc_q; // frozen while the read is in flight
    if (keep_word) begin
      instr_o    <= mem.rdata;
      instr_pc_o <= req_pc_q;
    end
  end

endmodule : fetch_unit

`default_nettype wire

/* logic/mem_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_stage #(
  parameter int DATA_WIDTH     = cpu_params_pkg::DATA_WIDTH,
  parameter int ADDR_WIDTH     = cpu_params_pkg::ADDR_WIDTH,
  parameter int REGISTER_WIDTH = cpu_params_pkg::REGISTER_WIDTH
)(
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     valid_i,
  input  logic                     is_load_i,
  input  logic                     is_store_i,
  input  logic                     reg_wr_en_i,
  input  cpu_params_pkg::word_t    alu_result_i,
  input  cpu_params_pkg::word_t    reg_a_data_i,
  input  cpu_params_pkg::reg_idx_t wr_reg_i,
  output logic                     stage_ready_o,
  output logic                     wb_valid_o,
  output logic                     wb_reg_wr_en_o,
  output logic                     wb_is_load_o,
  output cpu_params_pkg::reg_idx_t wb_wr_reg_o,
  output cpu_params_pkg::word_t    wb_alu_result_o,
  output cpu_params_pkg::word_t    wb_data_from_mem_o,
  mem_port_if.requester            mem
);

  typedef enum logic [1:0] {
    IDLE    = 2'b00,
    READY   = 2'b01,
    WAITING = 2'b10
  } state_t;

  state_t state_q, state_d;

  logic                      rd_req_q;
  logic                      wr_req_q;
  logic                      reg_wr_en_q;
  logic [DATA_WIDTH-1:0]     alu_q;   // load/store address, also written back
  logic [DATA_WIDTH-1:0]     wdata_q;
  logic [REGISTER_WIDTH-1:0] wr_reg_q;

  logic accept;
  logic mem_op;
  logic done;

  assign stage_ready_o = (state_q == READY);
  assign accept        = valid_i && stage_ready_o;
  assign mem_op        = is_load_i || is_store_i;
  assign done          = (state_q == WAITING) && (mem.rdata_valid || mem.wr_done);

  assign mem.rd_req = rd_req_q;
  assign mem.wr_req = wr_req_q;
  assign mem.addr   = alu_q[ADDR_WIDTH-1:0];
  assign mem.wdata  = wdata_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    state_d = READY;
      READY:   if (accept && mem_op) state_d = WAITING;
      WAITING: if (done) state_d = READY;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      state_q        <= IDLE;
      rd_req_q       <= 1'b0;
      wr_req_q       <= 1'b0;
      wb_valid_o     <= 1'b0;
      wb_reg_wr_en_o <= 1'b0;
      wb_is_load_o   <= 1'b0;
    end else begin
      state_q    <= state_d;
      wb_valid_o <= (accept && !mem_op) || done;
      if (accept && mem_op) begin
        rd_req_q <= is_load_i; // load wins if both are set
        wr_req_q <= is_store_i && !is_load_i;
      end else if (done) begin
        rd_req_q <= 1'b0;
        wr_req_q <= 1'b0;
      end
      if (accept && !mem_op) begin
        wb_reg_wr_en_o <= reg_wr_en_i;
        wb_is_load_o   <= 1'b0;
      end else if (done) begin
        wb_reg_wr_en_o <= reg_wr_en_q;
        wb_is_load_o   <= rd_req_q;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept && mem_op) begin
      alu_q       <= alu_result_i;
      wdata_q     <= reg_a_data_i;
      wr_reg_q    <= wr_reg_i;
      reg_wr_en_q <= reg_wr_en_i;
    end
    if (accept && !mem_op) begin
      wb_wr_reg_o     <= wr_reg_i;
      wb_alu_result_o <= alu_result_i;
    end else if (done) begin
      wb_wr_reg_o     <= wr_reg_q;
      wb_alu_result_o <= alu_q;
      if (rd_req_q) wb_data_from_mem_o <= mem.rdata;
    end
  end

endmodule : mem_stage

`default_nettype wire

/* logic/mem_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter #(
  parameter int DATA_WIDTH = cpu_params_pkg::DATA_WIDTH,
  parameter int ADDR_WIDTH = cpu_params_pkg::ADDR_WIDTH
)(
  input  logic          clk_i,
  input  logic          rst_i,
  mem_port_if.server    fetch_port,
  mem_port_if.server    data_port,
  mem_port_if.requester mem_port
);

  logic [mem_bus_pkg::NUM_REQUESTERS-1:0] req_vec;

  logic                    busy_q;   // one transaction outstanding
  mem_bus_pkg::requester_e owner_q;  // owner of that transaction
  mem_bus_pkg::requester_e prio_q;   // port that wins the next tie
  mem_bus_pkg::requester_e other;
  mem_bus_pkg::requester_e next_owner;
  mem_bus_pkg::requester_e cur;
  logic                    done;

  assign req_vec[mem_bus_pkg::REQ_FETCH] = fetch_port.rd_req || fetch_port.wr_req;
  assign req_vec[mem_bus_pkg::REQ_DATA]  = data_port.rd_req || data_port.wr_req;

  assign other      = (prio_q == mem_bus_pkg::REQ_FETCH) ? mem_bus_pkg::REQ_DATA
                                                         : mem_bus_pkg::REQ_FETCH;
  assign next_owner = req_vec[prio_q] ? prio_q : other;
  assign cur        = busy_q ? owner_q : next_owner; // grant is same-cycle
  assign done       = busy_q && (mem_port.rdata_valid || mem_port.wr_done);

  always_comb begin
    if (cur == mem_bus_pkg::REQ_DATA) begin
      mem_port.rd_req = data_port.rd_req;
      mem_port.wr_req = data_port.wr_req;
      mem_port.addr   = data_port.addr;
      mem_port.wdata  = data_port.wdata;
    end else begin
      mem_port.rd_req = fetch_port.rd_req;
      mem_port.wr_req = fetch_port.wr_req;
      mem_port.addr   = fetch_port.addr;
      mem_port.wdata  = fetch_port.wdata;
    end
  end

  // only the owner sees data and completions
  assign fetch_port.rdata       = (owner_q == mem_bus_pkg::REQ_FETCH) ? mem_port.rdata : '0;
  assign fetch_port.rdata_valid = busy_q && (owner_q == mem_bus_pkg::REQ_FETCH)
                                  && mem_port.rdata_valid;
  assign fetch_port.wr_done     = busy_q && (owner_q == mem_bus_pkg::REQ_FETCH)
                                  && mem_port.wr_done;
  assign data_port.rdata        = (owner_q == mem_bus_pkg::REQ_DATA) ? mem_port.rdata : '0;
  assign data_port.rdata_valid  = busy_q && (owner_q == mem_bus_pkg::REQ_DATA)
                                  && mem_port.rdata_valid;
  assign data_port.wr_done      = busy_q && (owner_q == mem_bus_pkg::REQ_DATA)
                                  && mem_port.wr_done;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      busy_q  <= 1'b0;
      owner_q <= mem_bus_pkg::REQ_FETCH;
      prio_q  <= mem_bus_pkg::REQ_FETCH;
    end else if (!busy_q && (|req_vec)) begin
      busy_q  <= 1'b1;
      owner_q <= next_owner;
    end else if (done) begin
      busy_q <= 1'b0;
      prio_q <= (owner_q == mem_bus_pkg::REQ_FETCH) ? mem_bus_pkg::REQ_DATA
                                                    : mem_bus_pkg::REQ_FETCH;
    end
  end

endmodule : mem_arbiter

`default_nettype wire

/* logic/unified_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module unified_mem #(
  parameter int DATA_WIDTH   = cpu_params_pkg::DATA_WIDTH,
  parameter int ADDR_WIDTH   = cpu_params_pkg::ADDR_WIDTH,
  parameter int MEM_SIZE     = cpu_params_pkg::MEM_SIZE,
  parameter int READ_LATENCY = cpu_params_pkg::READ_LATENCY
)(
  input  logic       clk_i,
  input  logic       rst_i,
  mem_port_if.server port
);

  localparam int IDX_WIDTH = $clog2(MEM_SIZE);
  localparam int CNT_WIDTH = $clog2(READ_LATENCY + 1);

  logic [DATA_WIDTH-1:0] mem_array [MEM_SIZE];
  logic [DATA_WIDTH-1:0] rdata_q;
  logic [CNT_WIDTH-1:0]  cnt_q;     // cycles left until rdata_valid
  logic                  rd_busy_q;
  logic                  wr_done_q;
  logic                  accept;
  logic [IDX_WIDTH-1:0]  idx;

  assign idx    = port.addr[IDX_WIDTH+1:2]; // word index from byte address
  assign accept = !rd_busy_q && !wr_done_q && (port.rd_req || port.wr_req);

  assign port.rdata       = rdata_q;
  assign port.rdata_valid = rd_busy_q && (cnt_q == '0);
  assign port.wr_done     = wr_done_q;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      rd_busy_q <= 1'b0;
      wr_done_q <= 1'b0;
      cnt_q     <= '0;
    end else begin
      wr_done_q <= accept && port.wr_req && !port.rd_req;
      if (accept && port.rd_req) begin
        rd_busy_q <= 1'b1;
        cnt_q     <= CNT_WIDTH'(READ_LATENCY - 1);
      end else if (rd_busy_q) begin
        if (cnt_q == '0) rd_busy_q <= 1'b0;
        else             cnt_q     <= cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept && port.rd_req) rdata_q <= mem_array[idx];
    else if (accept && port.wr_req) mem_array[idx] <= port.wdata;
  end

endmodule : unified_mem

`default_nettype wire

/* logic/mem_subsystem_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_top #(
  parameter int DATA_WIDTH     = cpu_params_pkg::DATA_WIDTH,
  parameter int ADDR_WIDTH     = cpu_params_pkg::ADDR_WIDTH,
  parameter int REGISTER_WIDTH = cpu_params_pkg::REGISTER_WIDTH,
  parameter int MEM_SIZE       = cpu_params_pkg::MEM_SIZE,
  parameter int READ_LATENCY   = cpu_params_pkg::READ_LATENCY
)(
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     fetch_en_i,
  input  logic                     redirect_i,
  input  cpu_params_pkg::addr_t    redirect_pc_i,
  output logic                     instr_valid_o,
  output cpu_params_pkg::word_t    instr_o,
  output cpu_params_pkg::addr_t    instr_pc_o,
  input  logic                     valid_i,
  input  logic                     is_load_i,
  input  logic                     is_store_i,
  input  logic                     reg_wr_en_i,
  input  cpu_params_pkg::word_t    alu_result_i,
  input  cpu_params_pkg::word_t    reg_a_data_i,
  input  cpu_params_pkg::reg_idx_t wr_reg_i,
  output logic                     stage_ready_o,
  output logic                     wb_valid_o,
  output logic                     wb_reg_wr_en_o,
  output logic                     wb_is_load_o,
  output cpu_params_pkg::reg_idx_t wb_wr_reg_o,
  output cpu_params_pkg::word_t    wb_alu_result_o,
  output cpu_params_pkg::word_t    wb_data_from_mem_o
);

  mem_port_if #(.DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)) fetch_if ();
  mem_port_if #(.DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)) data_if ();
  mem_port_if #(.DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)) mem_if ();

  fetch_unit #(
    .DATA_WIDTH(DATA_WIDTH),
    .ADDR_WIDTH(ADDR_WIDTH)
  ) fetch_unit_inst (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .fetch_en_i    (fetch_en_i),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .instr_valid_o (instr_valid_o),
    .instr_o       (instr_o),
    .instr_pc_o    (instr_pc_o),
    .mem           (fetch_if.requester)
  );

  mem_stage #(
    .DATA_WIDTH    (DATA_WIDTH),
    .ADDR_WIDTH    (ADDR_WIDTH),
    .REGISTER_WIDTH(REGISTER_WIDTH)
  ) mem_stage_inst (
    .clk_i              (clk_i),
    .rst_i              (rst_i),
    .valid_i            (valid_i),
    .is_load_i          (is_load_i),
    .is_store_i         (is_store_i),
    .reg_wr_en_i        (reg_wr_en_i),
    .alu_result_i       (alu_result_i),
    .reg_a_data_i       (reg_a_data_i),
    .wr_reg_i           (wr_reg_i),
    .stage_ready_o      (stage_ready_o),
    .wb_valid_o         (wb_valid_o),
    .wb_reg_wr_en_o     (wb_reg_wr_en_o),
    .wb_is_load_o       (wb_is_load_o),
    .wb_wr_reg_o        (wb_wr_reg_o),
    .wb_alu_result_o    (wb_alu_result_o),
    .wb_data_from_mem_o (wb_data_from_mem_o),
    .mem                (data_if.requester)
  );

  mem_arbiter #(
    .DATA_WIDTH(DATA_WIDTH),
    .ADDR_WIDTH(ADDR_WIDTH)
  ) mem_arbiter_inst (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .fetch_port (fetch_if.server),
    .data_port  (data_if.server),
    .mem_port   (mem_if.requester)
  );

  unified_mem #(
    .DATA_WIDTH  (DATA_WIDTH),
    .ADDR_WIDTH  (ADDR_WIDTH),
    .MEM_SIZE    (MEM_SIZE),
    .READ_LATENCY(READ_LATENCY)
  ) unified_mem_inst (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .port  (mem_if.server)
  );

endmodule : mem_subsystem_top

`default_nettype wire

/* verification/mem_subsystem_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_checker (
  input logic clk_i,
  input logic rst_i,
  input logic valid_i,
  input logic is_load_i,
  input logic is_store_i,
  input logic stage_ready_i,
  input logic wb_valid_i,
  input logic instr_valid_i
);

  logic accept;
  logic mem_pending_q; // load or store accepted, no writeback yet

  assign accept = valid_i && stage_ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      mem_pending_q <= 1'b0;
    end else if (accept && (is_load_i || is_store_i)) begin
      mem_pending_q <= 1'b1;
    end else if (wb_valid_i) begin
      mem_pending_q <= 1'b0;
    end
  end

  quiet_after_reset: assert property (@(posedge clk_i)
    $rose(rst_i) |=> (!wb_valid_i && !instr_valid_i))
    else $error("valid output high in the first cycle after reset");

  // a second pulse needs a new non-memory instruction accepted
  wb_single_pulse: assert property (@(posedge clk_i) disable iff (!rst_i)
    (wb_valid_i && !(accept && !is_load_i && !is_store_i)) |=> !wb_valid_i)
    else $error("wb_valid_o held high without a new instruction");

  ready_low_while_pending: assert property (@(posedge clk_i) disable iff (!rst_i)
    (mem_pending_q && !wb_valid_i) |-> !stage_ready_i)
    else $error("stage_ready_o high while a load or store is outstanding");

endmodule : mem_subsystem_checker

bind mem_subsystem_top mem_subsystem_checker mem_subsystem_checker_inst (
  .clk_i         (clk_i),
  .rst_i         (rst_i),
  .valid_i       (valid_i),
  .is_load_i     (is_load_i),
  .is_store_i    (is_store_i),
  .stage_ready_i (stage_ready_o),
  .wb_valid_i    (wb_valid_o),
  .instr_valid_i (instr_valid_o)
);

`default_nettype wire

/* verification/mem_subsystem_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_tb;

  localparam int TIMEOUT  = 200;
  localparam int MEM_SIZE = cpu_params_pkg::MEM_SIZE;

  logic                     clk_i;
  logic                     rst_i;
  logic                     fetch_en_i;
  logic                     redirect_i;
  cpu_params_pkg::addr_t    redirect_pc_i;
  logic                     instr_valid_o;
  cpu_params_pkg::word_t    instr_o;
  cpu_params_pkg::addr_t    instr_pc_o;
  logic                     valid_i;
  logic                     is_load_i;
  logic                     is_store_i;
  logic                     reg_wr_en_i;
  cpu_params_pkg::word_t    alu_result_i;
  cpu_params_pkg::word_t    reg_a_data_i;
  cpu_params_pkg::reg_idx_t wr_reg_i;
  logic                     stage_ready_o;
  logic                     wb_valid_o;
  logic                     wb_reg_wr_en_o;
  logic                     wb_is_load_o;
  cpu_params_pkg::reg_idx_t wb_wr_reg_o;
  cpu_params_pkg::word_t    wb_alu_result_o;
  cpu_params_pkg::word_t    wb_data_from_mem_o;

  cpu_params_pkg::word_t ref_mem [MEM_SIZE]; // what memory should hold
  logic                  known_word [MEM_SIZE]; // word written by a store
  cpu_params_pkg::addr_t fetch_pc;   // pc of the next expected instruction
  logic                  fetch_hold; // keep fetch_en_i on
  logic [31:0]           rnd;
  int                    instr_seen;

  mem_subsystem_top mem_subsystem_top_inst (
    .clk_i              (clk_i),
    .rst_i              (rst_i),
    .fetch_en_i         (fetch_en_i),
    .redirect_i         (redirect_i),
    .redirect_pc_i      (redirect_pc_i),
    .instr_valid_o      (instr_valid_o),
    .instr_o            (instr_o),
    .instr_pc_o         (instr_pc_o),
    .valid_i            (valid_i),
    .is_load_i          (is_load_i),
    .is_store_i         (is_store_i),
    .reg_wr_en_i        (reg_wr_en_i),
    .alu_result_i       (alu_result_i),
    .reg_a_data_i       (reg_a_data_i),
    .wr_reg_i           (wr_reg_i),
    .stage_ready_o      (stage_ready_o),
    .wb_valid_o         (wb_valid_o),
    .wb_reg_wr_en_o     (wb_reg_wr_en_o),
    .wb_is_load_o       (wb_is_load_o),
    .wb_wr_reg_o        (wb_wr_reg_o),
    .wb_alu_result_o    (wb_alu_result_o),
    .wb_data_from_mem_o (wb_data_from_mem_o)
  );

  always #4 clk_i = ~clk_i;

  function automatic logic [31:0] next_random(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic int word_index(input cpu_params_pkg::addr_t a);
    return (int'(a) >> 2) % MEM_SIZE; // byte address to word slot
  endfunction

  task automatic stop_failed();
    $display("Simulation failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_word(input string name, input cpu_params_pkg::word_t got,
                            input cpu_params_pkg::word_t exp);
    if (got !== exp) begin
      $display("Fail %s got %h expected %h", name, got, exp);
      stop_failed();
    end
  endtask

  task automatic check_reg(input string name, input cpu_params_pkg::reg_idx_t got,
                           input cpu_params_pkg::reg_idx_t exp);
    if (got !== exp) begin
      $display("Fail %s got %h expected %h", name, got, exp);
      stop_failed();
    end
  endtask

  task automatic check_addr(input string name, input cpu_params_pkg::addr_t got,
                            input cpu_params_pkg::addr_t exp);
    if (got !== exp) begin
      $display("Fail %s got %h expected %h", name, got, exp);
      stop_failed();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Fail %s got %h expected %h", name, got, exp);
      stop_failed();
    end
  endtask

  // one cycle, the fetch stream is checked on every falling edge
  task automatic step_cycle();
    @(negedge clk_i);
    if (instr_valid_o) begin
      check_addr("instr_pc_o", instr_pc_o, fetch_pc);
      check_word("instr_o", instr_o, ref_mem[word_index(fetch_pc)]);
      fetch_pc   = fetch_pc + cpu_params_pkg::addr_t'(4);
      instr_seen = instr_seen + 1;
    end
    rnd        = next_random(rnd);
    fetch_en_i = known_word[word_index(fetch_pc)] && (fetch_hold || rnd[0]);
  endtask

  task automatic run_data_op(input logic load, input logic store,
                             input cpu_params_pkg::word_t value,
                             input cpu_params_pkg::word_t data,
                             input cpu_params_pkg::reg_idx_t reg_idx);
    int n;
    n = 0;
    while (!stage_ready_o) begin
      if (n == TIMEOUT) begin
        $display("timeout while waiting for stage_ready_o");
        stop_failed();
      end
      step_cycle();
      n++;
    end
    valid_i      = 1'b1;
    is_load_i    = load;
    is_store_i   = store;
    reg_wr_en_i  = !store;
    alu_result_i = value;
    reg_a_data_i = data;
    wr_reg_i     = reg_idx;
    step_cycle(); // accepted on this rising edge
    valid_i    = 1'b0;
    is_load_i  = 1'b0;
    is_store_i = 1'b0;
    if (!load && !store) check_flag("wb_valid_o", wb_valid_o, 1'b1);
    n = 0;
    while (!wb_valid_o) begin
      if (n == TIMEOUT) begin
        $display("timeout while waiting for wb_valid_o");
        stop_failed();
      end
      step_cycle();
      n++;
    end
  endtask

  task automatic run_fetch(input cpu_params_pkg::addr_t stop_pc);
    int n;
    n = 0;
    fetch_hold = 1'b1;
    while (fetch_pc < stop_pc) begin
      if (n == TIMEOUT) begin
        $display("timeout while waiting for instr_valid_o before pc %h", stop_pc);
        stop_failed();
      end
      step_cycle();
      n++;
    end
    fetch_hold = 1'b0;
  endtask

  task automatic run_redirect(input cpu_params_pkg::addr_t new_pc,
                              input cpu_params_pkg::word_t first_word);
    int n;
    int seen;
    redirect_i    = 1'b1;
    redirect_pc_i = new_pc;
    fetch_pc      = new_pc; // any older word now fails the pc check
    fetch_hold    = 1'b1;
    step_cycle();
    redirect_i = 1'b0;
    seen       = instr_seen;
    n          = 0;
    while (instr_seen == seen) begin
      if (n == TIMEOUT) begin
        $display("timeout while waiting for instr_valid_o after a redirect");
        stop_failed();
      end
      step_cycle();
      n++;
    end
    check_word("instr_o", instr_o, first_word);
    fetch_hold = 1'b0;
  endtask

  initial begin
    int                       fd;
    int                       n;
    logic [63:0]              op;
    logic [8*96-1:0]          rest;
    cpu_params_pkg::word_t    value;
    cpu_params_pkg::word_t    data;
    cpu_params_pkg::word_t    expected;
    cpu_params_pkg::reg_idx_t reg_idx;
    cpu_params_pkg::addr_t    addr;

    clk_i         = 1'b0;
    rst_i         = 1'b0;
    fetch_en_i    = 1'b0;
    redirect_i    = 1'b0;
    redirect_pc_i = '0;
    valid_i       = 1'b0;
    is_load_i     = 1'b0;
    is_store_i    = 1'b0;
    reg_wr_en_i   = 1'b0;
    alu_result_i  = '0;
    reg_a_data_i  = '0;
    wr_reg_i      = '0;
    fetch_pc      = '0;
    fetch_hold    = 1'b0;
    instr_seen    = 0;
    rnd           = 32'd44958;
    for (int i = 0; i < MEM_SIZE; i++) begin
      ref_mem[i]    = '0;
      known_word[i] = 1'b0;
    end

    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b1;
    n     = 0;
    while (!stage_ready_o) begin
      if (n == TIMEOUT) begin
        $display("timeout while waiting for stage_ready_o after reset");
        stop_failed();
      end
      step_cycle();
      check_flag("wb_valid_o", wb_valid_o, 1'b0);
      check_flag("instr_valid_o", instr_valid_o, 1'b0);
      n++;
    end

    fd = $fopen("verification/mem_subsystem_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open verification/mem_subsystem_cases.txt");
      stop_failed();
    end
    while ($fscanf(fd, "%s", op) == 1) begin
      if (op == "#") begin
        n = $fgets(rest, fd); // comment line
      end else begin
        n = $fscanf(fd, "%h %h %h %h", value, data, reg_idx, expected);
        if (n != 4) begin
          $display("malformed line in the cases file");
          stop_failed();
        end
        addr = value[cpu_params_pkg::ADDR_WIDTH-1:0];
        if (op == "alu") begin
          run_data_op(1'b0, 1'b0, value, data, reg_idx);
          check_word("wb_alu_result_o", wb_alu_result_o, expected);
          check_reg("wb_wr_reg_o", wb_wr_reg_o, reg_idx);
          check_flag("wb_reg_wr_en_o", wb_reg_wr_en_o, 1'b1);
          check_flag("wb_is_load_o", wb_is_load_o, 1'b0);
        end else if (op == "store") begin
          run_data_op(1'b0, 1'b1, value, data, reg_idx);
          check_word("wb_alu_result_o", wb_alu_result_o, expected);
          check_flag("wb_reg_wr_en_o", wb_reg_wr_en_o, 1'b0);
          check_flag("wb_is_load_o", wb_is_load_o, 1'b0);
          ref_mem[word_index(addr)]    = data;
          known_word[word_index(addr)] = 1'b1;
        end else if (op == "load") begin
          run_data_op(1'b1, 1'b0, value, data, reg_idx);
          check_word("wb_data_from_mem_o", wb_data_from_mem_o, ref_mem[word_index(addr)]);
          check_word("wb_data_from_mem_o", wb_data_from_mem_o, expected);
          check_word("wb_alu_result_o", wb_alu_result_o, value);
          check_reg("wb_wr_reg_o", wb_wr_reg_o, reg_idx);
          check_flag("wb_reg_wr_en_o", wb_reg_wr_en_o, 1'b1);
          check_flag("wb_is_load_o", wb_is_load_o, 1'b1);
        end else if (op == "fetch") begin
          run_fetch(addr);
        end else if (op == "redirect") begin
          run_redirect(addr, expected);
        end else begin
          $display("unknown operation in the cases file");
          stop_failed();
        end
      end
    end
    $fclose(fd);

    repeat (4) step_cycle();
    $display("Simulation passed");
    $finish;
  end

endmodule : mem_subsystem_tb

`default_nettype wire

/* verification/mem_subsystem_cases.txt */
# op value data reg expected, all hex; value is the address for load and store,
# the stop pc for fetch and the new pc for redirect, whose expected is the first word
store 00000100 23000101 00 00000100
store 00000104 23000102 00 00000104
store 00000108 23000103 00 00000108
store 0000010c 23000104 00 0000010c
store 00000000 13000001 00 00000000
store 00000004 13000002 00 00000004
store 00000008 13000003 00 00000008
store 0000000c 13000004 00 0000000c
store 00000010 13000005 00 00000010
store 00000014 13000006 00 00000014
alu 0000abcd 00000000 03 0000abcd
fetch 00000008 00000000 00 00000000
redirect 00000100 00000000 00 23000101
store 00000200 cafef00d 00 00000200
load 00000200 00000000 05 cafef00d
alu 12345678 deadbeef 1f 12345678
load 00000004 00000000 0a 13000002
store 00000204 0badc0de 00 00000204
load 00000204 00000000 11 0badc0de
load 00000014 00000000 02 13000006
store 00000200 55aa55aa 00 00000200
load 00000200 00000000 07 55aa55aa
fetch 00000110 00000000 00 00000000

/* mem_subsystem.f */
logic/cpu_params_pkg.sv
logic/mem_bus_pkg.sv
logic/mem_port_if.sv
logic/fetch_unit.sv
logic/mem_stage.sv
logic/mem_arbiter.sv
logic/unified_mem.sv
logic/mem_subsystem_top.sv
verification/mem_subsystem_checker.sv
verification/mem_subsystem_tb.sv

/* Makefile */
# Verilator build of the memory subsystem testbench

TOP = mem_subsystem_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		--top-module $(TOP) -f mem_subsystem.f -o $(TOP)

run: compile
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
